// ==== tile_binner.f ====
rtl/bin_pkg.sv
rtl/bin_fsm.sv
rtl/tile_walker.sv
rtl/edge_eval.sv
rtl/tile_binner.sv
bench/tile_binner_assert.sv
bench/tb_tile_binner.sv

// ==== Makefile ====
# Verilator build and run of the tile binner testbench
TOP := tb_tile_binner

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, log to sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f tile_binner.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "test failed"; exit 1; fi
	@grep -q "NO ERRORS" sim.log || (echo "simulation ended early"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_tile_binner.sv ====
/*
 * self-checking testbench for tile_binner, one triangle in flight at a time
 * random grids stay near the origin so no tile position wraps
 */
`timescale 1ns/100ps

module tb_tile_binner import bin_pkg::*; ();

    localparam int          CLK_HALF     = 2;        // 4 ns period
    localparam logic [31:0] LFSR_SEED    = 32'h3a7bbde7;
    localparam int          BUSY_TIMEOUT = 20000;    // cycles per triangle
    localparam int          DEST_REJECT  = 0;
    localparam int          DEST_RASTER  = 1;
    localparam int          DEST_SHADER  = 2;

    logic   clk;
    logic   rstn;
    logic   i_valid;
    coef_t  i_e0_a, i_e0_b, i_e0_c;
    coef_t  i_e1_a, i_e1_b, i_e1_c;
    coef_t  i_e2_a, i_e2_b, i_e2_c;
    coord_t i_min_x;
    coord_t i_min_y;
    step_t  i_step_x;
    step_t  i_step_y;
    logic   i_raster_full;
    logic   i_shader_full;
    coord_t o_tile_x;
    coord_t o_tile_y;
    logic   o_raster_wr;
    logic   o_shader_wr;
    logic   o_busy;

    coef_t       tri_a [3];     // current triangle
    coef_t       tri_b [3];
    coef_t       tri_c [3];
    coord_t      exp_x [$];     // expected writes in order
    coord_t      exp_y [$];
    logic        exp_shader [$];
    logic [31:0] lfsr_state;
    logic        bp_en;         // random queue full pulses
    logic        timed_out;
    int          n_checks;
    int          n_value_err;
    int          n_other_err;
    int          n_assert_fail;

    tile_binner tile_binner_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};  // one step per bit
        end
        return v;
    endfunction

    function automatic int rand_range(input int lo, input int n_bits);
        return lo + int'(rand_bits(n_bits));
    endfunction

    function automatic longint edge_value(input int k, input longint px, input longint py);
        return longint'(tri_a[k]) * px + longint'(tri_b[k]) * py + longint'(tri_c[k]);
    endfunction

    // out if some edge is negative at every corner, full if no edge is negative anywhere
    function automatic int classify_tile(input longint x, input longint y);
        longint e;
        longint e_max;
        longint e_min;
        logic   any_out;
        logic   any_neg;
        any_out = 1'b0;
        any_neg = 1'b0;
        for (int k = 0; k < 3; k++) begin
            e_max = edge_value(k, x, y);
            e_min = e_max;
            for (int c = 1; c < 4; c++) begin
                e = edge_value(k, x + ((c & 1) ? TILE_MAX_OFS : 0),
                               y + ((c & 2) ? TILE_MAX_OFS : 0));
                if (e > e_max) e_max = e;
                if (e < e_min) e_min = e;
            end
            if (e_max < 0) any_out = 1'b1;
            if (e_min < 0) any_neg = 1'b1;
        end
        if (any_out) return DEST_REJECT;
        else if (any_neg) return DEST_RASTER;
        return DEST_SHADER;
    endfunction

    task automatic check_coord(input string what, input coord_t expected, input coord_t actual);
        n_checks++;
        if (actual !== expected) begin
            $display("error at %0d ns: %s is %0d, expected %0d", $time, what, actual, expected);
            n_value_err++;
        end
    endtask

    task automatic check_dest(input logic expected_shader, input logic got_shader);
        n_checks++;
        if (got_shader !== expected_shader) begin
            $display("error at %0d ns: tile went to the %s queue, expected the %s queue", $time,
                     got_shader ? "shader" : "raster", expected_shader ? "shader" : "raster");
            n_value_err++;
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        n_checks++;
        if (actual !== expected) begin
            $display("error at %0d ns: %s is %b, expected %b", $time, what, actual, expected);
            n_value_err++;
        end
    endtask

    task automatic set_edge(input int k, input int a, input int b, input int c);
        tri_a[k] = coef_t'(a);
        tri_b[k] = coef_t'(b);
        tri_c[k] = coef_t'(c);
    endtask

    task automatic apply_edges();
        i_e0_a = tri_a[0];
        i_e0_b = tri_b[0];
        i_e0_c = tri_c[0];
        i_e1_a = tri_a[1];
        i_e1_b = tri_b[1];
        i_e1_c = tri_c[1];
        i_e2_a = tri_a[2];
        i_e2_b = tri_b[2];
        i_e2_c = tri_c[2];
    endtask

    // raster order, x first
    task automatic push_expected(input coord_t min_x, input coord_t min_y,
                                 input step_t step_x, input step_t step_y);
        longint px;
        longint py;
        int     dest;
        for (int row = 0; row <= int'(step_y); row++) begin
            for (int col = 0; col <= int'(step_x); col++) begin
                px = longint'(min_x) + col * TILE_SIZE;
                py = longint'(min_y) + row * TILE_SIZE;
                dest = classify_tile(px, py);
                if (dest != DEST_REJECT) begin
                    exp_x.push_back(coord_t'(px));
                    exp_y.push_back(coord_t'(py));
                    exp_shader.push_back(dest == DEST_SHADER);
                end
            end
        end
    endtask

    task automatic drive_backpressure();
        if (bp_en) begin
            i_raster_full = (rand_bits(2) == 0);
            i_shader_full = (rand_bits(2) == 0);
        end else begin
            i_raster_full = 1'b0;
            i_shader_full = 1'b0;
        end
    endtask

    task automatic run_triangle(input coord_t min_x, input coord_t min_y,
                                input step_t step_x, input step_t step_y);
        int cnt;
        if (timed_out) return;
        @(negedge clk);
        apply_edges();
        i_min_x  = min_x;
        i_min_y  = min_y;
        i_step_x = step_x;
        i_step_y = step_y;
        i_valid  = 1'b1;
        drive_backpressure();
        push_expected(min_x, min_y, step_x, step_y);
        @(negedge clk);
        i_valid = 1'b0;
        cnt = 0;
        while (o_busy && cnt < BUSY_TIMEOUT) begin
            @(negedge clk);
            drive_backpressure();
            cnt++;
        end
        if (o_busy) begin
            $display("timeout, o_busy still high after %0d cycles", cnt);
            n_other_err++;
            timed_out = 1'b1;
        end
        i_raster_full = 1'b0;
        i_shader_full = 1'b0;
        if (exp_x.size() != 0) begin
            $display("%0d expected tiles were never written", exp_x.size());
            n_other_err++;
            exp_x.delete();
            exp_y.delete();
            exp_shader.delete();
        end
    endtask

    // edges pass through a random point of the grid
    task automatic random_case();
        coord_t min_x;
        coord_t min_y;
        step_t  step_x;
        step_t  step_y;
        int     a;
        int     b;
        int     px;
        int     py;
        min_x  = coord_t'(rand_range(-128, 8));
        min_y  = coord_t'(rand_range(-128, 8));
        step_x = step_t'(rand_bits(3));
        step_y = step_t'(rand_bits(3));
        for (int k = 0; k < 3; k++) begin
            a  = rand_range(-32, 6);
            b  = rand_range(-32, 6);
            px = int'(min_x) + rand_range(0, 6);
            py = int'(min_y) + rand_range(0, 6);
            set_edge(k, a, b, rand_range(-64, 7) - a * px - b * py);
        end
        run_triangle(min_x, min_y, step_x, step_y);
    endtask

    // compares every accepted write with the next expected tile
    always @(posedge clk) begin
        if (rstn && (o_raster_wr || o_shader_wr)) begin
            if (exp_x.size() == 0) begin
                $display("unexpected tile write at %0d ns, no tile was left to write", $time);
                n_other_err++;
            end else begin
                check_coord("tile x", exp_x.pop_front(), o_tile_x);
                check_coord("tile y", exp_y.pop_front(), o_tile_y);
                check_dest(exp_shader.pop_front(), o_shader_wr);
            end
        end
    end

    initial begin
        rstn          = 1'b0;
        i_valid       = 1'b0;
        i_min_x       = '0;
        i_min_y       = '0;
        i_step_x      = '0;
        i_step_y      = '0;
        i_raster_full = 1'b0;
        i_shader_full = 1'b0;
        for (int k = 0; k < 3; k++) set_edge(k, 0, 0, 0);
        apply_edges();
        lfsr_state  = LFSR_SEED;
        bp_en       = 1'b0;
        timed_out   = 1'b0;
        n_checks    = 0;
        n_value_err = 0;
        n_other_err = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        repeat (10) begin  // idle until the first triangle
            @(negedge clk);
            check_flag("o_busy", 1'b0, o_busy);
            check_flag("o_raster_wr", 1'b0, o_raster_wr);
            check_flag("o_shader_wr", 1'b0, o_shader_wr);
        end

        set_edge(0, 1, 0, 1000);   // covers the whole grid
        set_edge(1, 0, 1, 1000);
        set_edge(2, -1, -1, 2000);
        run_triangle(16'sd0, 16'sd0, 8'd3, 8'd2);

        set_edge(0, 1, 0, -5000);  // far right of the grid
        run_triangle(16'sd16, 16'sd8, 8'd2, 8'd2);

        set_edge(0, 1, 0, -4);     // crosses the grid
        set_edge(1, 0, 1, -4);
        set_edge(2, -1, -1, 40);
        run_triangle(16'sd0, 16'sd0, 8'd5, 8'd5);
        run_triangle(16'sd0, 16'sd0, 8'd0, 8'd0);
        run_triangle(16'sd16, 16'sd16, 8'd0, 8'd0);
        run_triangle(16'sd40, 16'sd40, 8'd0, 8'd0);

        bp_en = 1'b1;
        run_triangle(-16'sd8, -16'sd8, 8'd6, 8'd6);
        run_triangle(16'sd8, 16'sd0, 8'd0, 8'd0);

        for (int i = 0; i < 50; i++) begin
            bp_en = i[0];
            random_case();
        end

        @(negedge clk);
        n_assert_fail = tile_binner_inst.tile_binner_assert_inst.n_fail;
        $display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 n_checks, n_value_err, n_other_err, n_assert_fail);
        if (n_value_err == 0 && n_other_err == 0 && n_assert_fail == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== bench/tile_binner_assert.sv ====
/*
 * port protocol checks, bound into every tile_binner instance
 * checks are idle while rstn is low
 */
`timescale 1ns/100ps

module tile_binner_assert (
    input logic clk,
    input logic rstn,
    input logic i_valid,
    input logic i_raster_full,
    input logic i_shader_full,
    input logic i_raster_wr,
    input logic i_shader_wr,
    input logic i_busy
);

    int n_fail = 0;  // failed assertions so far

    a_one_strobe: assert property (@(posedge clk) disable iff (!rstn)
        !(i_raster_wr && i_shader_wr))
        else begin
            $error("raster and shader writes in the same cycle");
            n_fail++;
        end

    a_raster_full: assert property (@(posedge clk) disable iff (!rstn)
        i_raster_full |-> !i_raster_wr)
        else begin
            $error("raster write while the raster queue is full");
            n_fail++;
        end

    a_shader_full: assert property (@(posedge clk) disable iff (!rstn)
        i_shader_full |-> !i_shader_wr)
        else begin
            $error("shader write while the shader queue is full");
            n_fail++;
        end

    a_wr_busy: assert property (@(posedge clk) disable iff (!rstn)
        (i_raster_wr || i_shader_wr) |-> i_busy)
        else begin
            $error("queue write while not busy");
            n_fail++;
        end

    // accepted triangle
    a_busy_rise: assert property (@(posedge clk) disable iff (!rstn)
        (i_valid && !i_busy) |=> i_busy)
        else begin
            $error("busy did not rise after an accepted triangle");
            n_fail++;
        end

endmodule

bind tile_binner tile_binner_assert tile_binner_assert_inst (
    .clk           (clk),
    .rstn          (rstn),
    .i_valid       (i_valid),
    .i_raster_full (i_raster_full),
    .i_shader_full (i_shader_full),
    .i_raster_wr   (o_raster_wr),
    .i_shader_wr   (o_shader_wr),
    .i_busy        (o_busy)
);

// ==== rtl/tile_binner.sv ====
/*
 * tile binner top, one triangle at a time
 * i_valid is taken only while o_busy is low
 * each tile goes to the raster queue, the shader queue or nowhere
 */
`timescale 1ns/100ps

module tile_binner import bin_pkg::*; (
    input  logic   clk,
    input  logic   rstn,
    input  logic   i_valid,
    input  coef_t  i_e0_a,
    input  coef_t  i_e0_b,
    input  coef_t  i_e0_c,
    input  coef_t  i_e1_a,
    input  coef_t  i_e1_b,
    input  coef_t  i_e1_c,
    input  coef_t  i_e2_a,
    input  coef_t  i_e2_b,
    input  coef_t  i_e2_c,
    input  coord_t i_min_x,
    input  coord_t i_min_y,
    input  step_t  i_step_x,
    input  step_t  i_step_y,
    input  logic   i_raster_full,
    input  logic   i_shader_full,
    output coord_t o_tile_x,
    output coord_t o_tile_y,
    output logic   o_raster_wr,
    output logic   o_shader_wr,
    output logic   o_busy
);

    logic      load;       // triangle accepted
    logic      step;
    logic      last_tile;
    logic      req;
    edge_idx_t req_edge;
    logic      req_acc;
    logic      res_valid;
    logic      res_neg;

    bin_fsm bin_fsm_inst (
        .clk           (clk),
        .rstn          (rstn),
        .i_valid       (i_valid),
        .i_raster_full (i_raster_full),
        .i_shader_full (i_shader_full),
        .i_last_tile   (last_tile),
        .i_res_valid   (res_valid),
        .i_res_neg     (res_neg),
        .o_busy        (o_busy),
        .o_load        (load),
        .o_step        (step),
        .o_req         (req),
        .o_req_edge    (req_edge),
        .o_req_acc     (req_acc),
        .o_raster_wr   (o_raster_wr),
        .o_shader_wr   (o_shader_wr)
    );

    tile_walker tile_walker_inst (
        .clk      (clk),
        .rstn     (rstn),
        .i_load   (load),
        .i_step   (step),
        .i_min_x  (i_min_x),
        .i_min_y  (i_min_y),
        .i_step_x (i_step_x),
        .i_step_y (i_step_y),
        .o_tile_x (o_tile_x),
        .o_tile_y (o_tile_y),
        .o_last   (last_tile)
    );

    // evaluator reads the walker position directly
    edge_eval edge_eval_inst (
        .clk         (clk),
        .rstn        (rstn),
        .i_load      (load),
        .i_e0_a      (i_e0_a),
        .i_e0_b      (i_e0_b),
        .i_e0_c      (i_e0_c),
        .i_e1_a      (i_e1_a),
        .i_e1_b      (i_e1_b),
        .i_e1_c      (i_e1_c),
        .i_e2_a      (i_e2_a),
        .i_e2_b      (i_e2_b),
        .i_e2_c      (i_e2_c),
        .i_tile_x    (o_tile_x),
        .i_tile_y    (o_tile_y),
        .i_req       (req),
        .i_req_edge  (req_edge),
        .i_req_acc   (req_acc),
        .o_res_valid (res_valid),
        .o_res_neg   (res_neg)
    );

endmodule

// ==== rtl/edge_eval.sv ====
/*
 * evaluates one edge function at a tile corner, two cycle latency
 * one request per cycle, tile position must hold while requests are in flight
 * only the sign of e is returned
 */
`timescale 1ns/100ps

module edge_eval import bin_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      i_load,
    input  coef_t     i_e0_a,
    input  coef_t     i_e0_b,
    input  coef_t     i_e0_c,
    input  coef_t     i_e1_a,
    input  coef_t     i_e1_b,
    input  coef_t     i_e1_c,
    input  coef_t     i_e2_a,
    input  coef_t     i_e2_b,
    input  coef_t     i_e2_c,
    input  coord_t    i_tile_x,
    input  coord_t    i_tile_y,
    input  logic      i_req,
    input  edge_idx_t i_req_edge,
    input  logic      i_req_acc,
    output logic      o_res_valid,
    output logic      o_res_neg
);

    coef_t  edge_a [3];
    coef_t  edge_b [3];
    coef_t  edge_c [3];
    coef_t  sel_a;
    coef_t  sel_b;
    coef_t  sel_c;
    efunc_t pos_x;        // corner position
    efunc_t pos_y;
    efunc_t prod_x;       // stage one
    efunc_t prod_y;
    efunc_t c_s1;
    logic   s1_valid;

    always_ff @(posedge clk) begin
        if (i_load) begin
            edge_a <= '{i_e0_a, i_e1_a, i_e2_a};
            edge_b <= '{i_e0_b, i_e1_b, i_e2_b};
            edge_c <= '{i_e0_c, i_e1_c, i_e2_c};
        end
    end

    always_comb begin
        case (i_req_edge)
            2'd0:    sel_a = edge_a[0];
            2'd1:    sel_a = edge_a[1];
            default: sel_a = edge_a[2];
        endcase
        case (i_req_edge)
            2'd0:    sel_b = edge_b[0];
            2'd1:    sel_b = edge_b[1];
            default: sel_b = edge_b[2];
        endcase
        case (i_req_edge)
            2'd0:    sel_c = edge_c[0];
            2'd1:    sel_c = edge_c[1];
            default: sel_c = edge_c[2];
        endcase
    end

    // reject corner takes the far offset where the coefficient is >= 0, accept the other
    assign pos_x = efunc_t'(i_tile_x)
                 + ((sel_a[15] == i_req_acc) ? efunc_t'(TILE_MAX_OFS) : efunc_t'(0));
    assign pos_y = efunc_t'(i_tile_y)
                 + ((sel_b[15] == i_req_acc) ? efunc_t'(TILE_MAX_OFS) : efunc_t'(0));

    always_ff @(posedge clk) begin
        prod_x    <= efunc_t'(sel_a) * pos_x;
        prod_y    <= efunc_t'(sel_b) * pos_y;
        c_s1      <= efunc_t'(sel_c);
        o_res_neg <= efunc_t'(prod_x + prod_y + c_s1) < 0;  // stage two
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid    <= 1'b0;
            o_res_valid <= 1'b0;
        end else begin
            s1_valid    <= i_req;
            o_res_valid <= s1_valid;
        end
    end

endmodule

// ==== rtl/tile_walker.sv ====
/*
 * walks the tile grid in raster order, x first
 * o_last is combinational and valid only after a load
 */
`timescale 1ns/100ps

module tile_walker import bin_pkg::*; (
    input  logic   clk,
    input  logic   rstn,
    input  logic   i_load,
    input  logic   i_step,
    input  coord_t i_min_x,
    input  coord_t i_min_y,
    input  step_t  i_step_x,
    input  step_t  i_step_y,
    output coord_t o_tile_x,
    output coord_t o_tile_y,
    output logic   o_last
);

    coord_t org_x;        // row restart position
    step_t  step_x_r;
    step_t  step_y_r;
    step_t  col_cnt;
    step_t  row_cnt;

    assign o_last = (col_cnt == step_x_r) && (row_cnt == step_y_r);

    // grid counters
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (i_load) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (i_step) begin
            if (col_cnt == step_x_r) begin  // end of row
                col_cnt <= '0;
                row_cnt <= row_cnt + 8'd1;
            end else begin
                col_cnt <= col_cnt + 8'd1;
            end
        end
    end

    // origin, limits and position
    always_ff @(posedge clk) begin
        if (i_load) begin
            org_x    <= i_min_x;
            step_x_r <= i_step_x;
            step_y_r <= i_step_y;
            o_tile_x <= i_min_x;
            o_tile_y <= i_min_y;
        end else if (i_step) begin
            if (col_cnt == step_x_r) begin
                o_tile_x <= org_x;
                o_tile_y <= o_tile_y + coord_t'(TILE_SIZE);
            end else begin
                o_tile_x <= o_tile_x + coord_t'(TILE_SIZE);
            end
        end
    end

endmodule

// ==== rtl/bin_fsm.sv ====
/*
 * sequences the corner tests of one tile at a time
 * expects edge results exactly two cycles after each request
 * queue writes stall without limit while the matching queue is full
 */
`timescale 1ns/100ps

module bin_fsm import bin_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      i_valid,
    input  logic      i_raster_full,
    input  logic      i_shader_full,
    input  logic      i_last_tile,
    input  logic      i_res_valid,
    input  logic      i_res_neg,
    output logic      o_busy,
    output logic      o_load,
    output logic      o_step,
    output logic      o_req,
    output edge_idx_t o_req_edge,
    output logic      o_req_acc,
    output logic      o_raster_wr,
    output logic      o_shader_wr
);

    bin_state_t state;
    edge_idx_t  issue_cnt;  // requests issued, then results seen in WAIT
    logic       neg_flag;   // sticky, some edge negative in this phase
    logic       neg_now;

    // include the result arriving this cycle
    assign neg_now = neg_flag | (i_res_valid & i_res_neg);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= IDLE;
            issue_cnt <= '0;
            neg_flag  <= 1'b0;
        end else begin
            if (i_res_valid && i_res_neg) begin
                neg_flag <= 1'b1;
            end
            case (state)
                IDLE: begin
                    if (i_valid) begin
                        state     <= TEST_REJ;
                        issue_cnt <= '0;
                        neg_flag  <= 1'b0;
                    end
                end
                TEST_REJ, TEST_ACC: begin
                    if (issue_cnt == 2'd2) begin  // third request goes out now
                        state     <= (state == TEST_REJ) ? WAIT_REJ : WAIT_ACC;
                        issue_cnt <= '0;
                    end else begin
                        issue_cnt <= issue_cnt + 2'd1;
                    end
                end
                WAIT_REJ, WAIT_ACC: begin
                    // first sign already landed during TEST
                    if (i_res_valid) begin
                        if (issue_cnt == 2'd1) begin
                            issue_cnt <= '0;
                            neg_flag  <= 1'b0;
                            if (state == WAIT_REJ) begin
                                state <= neg_now ? STEP : TEST_ACC;  // reject or go on
                            end else begin
                                state <= neg_now ? OUT_RASTER : OUT_SHADER;
                            end
                        end else begin
                            issue_cnt <= issue_cnt + 2'd1;
                        end
                    end
                end
                OUT_RASTER: begin
                    if (!i_raster_full) state <= STEP;
                end
                OUT_SHADER: begin
                    if (!i_shader_full) state <= STEP;
                end
                STEP: begin
                    state <= i_last_tile ? IDLE : TEST_REJ;
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign o_busy      = (state != IDLE);
    assign o_load      = (state == IDLE) && i_valid;
    assign o_step      = (state == STEP) && !i_last_tile;  // walker moves at end of STEP
    assign o_req       = (state == TEST_REJ) || (state == TEST_ACC);
    assign o_req_edge  = issue_cnt;
    assign o_req_acc   = (state == TEST_ACC);
    assign o_raster_wr = (state == OUT_RASTER) && !i_raster_full;
    assign o_shader_wr = (state == OUT_SHADER) && !i_shader_full;

endmodule

// ==== rtl/bin_pkg.sv ====
/*
 * shared widths and constants of the tile binner
 * tile size is fixed at build time and must be a power of two
 */
package bin_pkg;

    // tile geometry in pixels
    localparam int TILE_SIZE    = 8;
    localparam int TILE_MAX_OFS = TILE_SIZE - 1;  // far corner offset inside a tile

    // signed pixel coordinate
    typedef logic signed [15:0] coord_t;

    // edge coefficients a, b and c
    typedef logic signed [15:0] coef_t;

    // e = a*x + b*y + c, two 33 bit products plus c never overflow 36 bits
    typedef logic signed [35:0] efunc_t;

    // extra tiles along one axis, so a grid is step + 1 tiles wide
    typedef logic [7:0] step_t;

    // edge number 0..2
    typedef logic [1:0] edge_idx_t;

    typedef enum logic [2:0] {
        IDLE,        // waiting for a triangle
        TEST_REJ,    // issue reject corner requests
        WAIT_REJ,    // collect reject corner signs
        TEST_ACC,    // issue accept corner requests
        WAIT_ACC,    // collect accept corner signs
        OUT_RASTER,  // partial tile, write raster queue
        OUT_SHADER,  // full tile, write shader queue
        STEP         // next tile or done
    } bin_state_t;

endpackage
